// ==== all.f ====
logic/axi_pkg.sv
logic/regbank_pkg.sv
logic/axil_if.sv
logic/reg_bank.sv
logic/axil_bank_arbiter.sv
logic/axi_reflect_wr.sv
logic/axi_reflect_rd.sv
logic/axi_reflect_top.sv
tests/axi_reflect_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI reflector testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
SIM_BIN=axi_reflect_sim

verilator --binary --timing --timescale 1ns/1ps \
  -f all.f \
  --top-module axi_reflect_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -qx "CHECKS FAILED" "$LOG_FILE"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without failure"
exit 0

// ==== tests/axi_reflect_tb.sv ====
`timescale 1ns/1ps

module axi_reflect_tb;
  import axi_pkg::*;

  localparam int ADDR_WIDTH = 20;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  localparam int USER_WIDTH = 2;
  localparam int REG_COUNT  = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int OFFSET     = $clog2(STRB_WIDTH);
  localparam int TIMEOUT    = 1000; // Cycles per wait.
  localparam int SEQ_OPS    = 10;
  localparam int MIX_OPS    = 12;
  localparam logic [2:0] FULL_SIZE  = 3'(OFFSET);
  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [USER_WIDTH-1:0] user_t;

  typedef struct packed {
    id_t       id;
    user_t     user;
    axi_resp_t resp;
  } b_exp_t;

  typedef struct packed {
    data_t     data;
    id_t       id;
    user_t     user;
    axi_resp_t resp;
    logic      last;
  } r_exp_t;

  logic      clk;
  logic      rst_n;
  logic      s_axi_awvalid;
  addr_t     s_axi_awaddr;
  id_t       s_axi_awid;
  axi_len_t  s_axi_awlen;
  logic [2:0] s_axi_awsize;
  logic [1:0] s_axi_awburst;
  user_t     s_axi_awuser;
  logic      s_axi_awready;
  logic      s_axi_wvalid;
  data_t     s_axi_wdata;
  strb_t     s_axi_wstrb;
  logic      s_axi_wlast;
  logic      s_axi_wready;
  logic      s_axi_bvalid;
  id_t       s_axi_bid;
  axi_resp_t s_axi_bresp;
  user_t     s_axi_buser;
  logic      s_axi_bready = 1'b1;
  logic      s_axi_arvalid;
  addr_t     s_axi_araddr;
  id_t       s_axi_arid;
  axi_len_t  s_axi_arlen;
  logic [2:0] s_axi_arsize;
  logic [1:0] s_axi_arburst;
  user_t     s_axi_aruser;
  logic      s_axi_arready;
  logic      s_axi_rvalid;
  data_t     s_axi_rdata;
  id_t       s_axi_rid;
  axi_resp_t s_axi_rresp;
  user_t     s_axi_ruser;
  logic      s_axi_rlast;
  logic      s_axi_rready = 1'b1;

  logic [31:0] lfsr_state = 32'd92992;
  logic [31:0] ready_bits;
  logic        bp_on = 1'b0; // Random bready and rready.
  data_t       model [REG_COUNT];
  b_exp_t      exp_b [$];
  r_exp_t      exp_r [$];
  b_exp_t      b_e;
  r_exp_t      r_e;
  addr_t       seq_addr [SEQ_OPS];
  addr_t       mix_waddr [MIX_OPS];
  data_t       mix_wdata [MIX_OPS];
  strb_t       mix_wstrb [MIX_OPS];
  addr_t       mix_raddr [MIX_OPS];
  b_exp_t      mix_b [MIX_OPS];
  r_exp_t      mix_r [MIX_OPS];

  axi_reflect_top #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH),
    .USER_WIDTH(USER_WIDTH),
    .REG_COUNT (REG_COUNT)
  ) axi_reflect_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ##################################################
  // Random source, reference model and reporting
  // ##################################################

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Expected response of one access; updates the model on in-range writes.
  function automatic axi_resp_t model_access(input logic we, input addr_t addr,
                                             input data_t wdata, input strb_t wstrb,
                                             output data_t rdata);
    int idx;
    idx = int'(addr >> OFFSET);
    rdata = '0;
    if (idx >= REG_COUNT) return RESP_DECERR;
    if (we) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wstrb[b]) model[idx][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    rdata = model[idx];
    return RESP_OKAY;
  endfunction

  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic tick_wait(inout int cycles, input string what);
    @(negedge clk);
    cycles++;
    if (cycles > TIMEOUT) report_failure($sformatf("Timeout waiting for %s", what));
  endtask

  // ##################################################
  // Bus drivers
  // ##################################################

  task automatic issue_write(input addr_t addr, input data_t data, input strb_t strb,
                             input id_t id, input user_t user, input axi_len_t len);
    int cycles;
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b1;
    s_axi_awaddr  = addr;
    s_axi_awid    = id;
    s_axi_awuser  = user;
    s_axi_awlen   = len;
    s_axi_wvalid  = 1'b1;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wlast   = (len == '0);
    cycles = 0;
    do tick_wait(cycles, "AW handshake"); while (!s_axi_awready);
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      s_axi_wdata = data ^ data_t'(i); // Distinct beats.
      s_axi_wlast = (i == int'(len));
      cycles = 0;
      do tick_wait(cycles, "W handshake"); while (!s_axi_wready);
      @(posedge clk);
      #1;
    end
    s_axi_wvalid = 1'b0;
  endtask

  task automatic issue_read(input addr_t addr, input id_t id, input user_t user,
                            input axi_len_t len);
    int cycles;
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b1;
    s_axi_araddr  = addr;
    s_axi_arid    = id;
    s_axi_aruser  = user;
    s_axi_arlen   = len;
    cycles = 0;
    do tick_wait(cycles, "AR handshake"); while (!s_axi_arready);
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b0;
  endtask

  task automatic write_checked(input addr_t addr, input data_t data, input strb_t strb);
    b_exp_t e;
    data_t  unused_rd;
    e.id   = id_t'(rand_bits(ID_WIDTH));
    e.user = user_t'(rand_bits(USER_WIDTH));
    e.resp = model_access(1'b1, addr, data, strb, unused_rd);
    exp_b.push_back(e);
    issue_write(addr, data, strb, e.id, e.user, '0);
  endtask

  task automatic read_checked(input addr_t addr);
    r_exp_t e;
    data_t  rdata;
    e.id   = id_t'(rand_bits(ID_WIDTH));
    e.user = user_t'(rand_bits(USER_WIDTH));
    e.resp = model_access(1'b0, addr, '0, '0, rdata);
    e.data = rdata;
    e.last = 1'b1;
    exp_r.push_back(e);
    issue_read(addr, e.id, e.user, '0);
  endtask

  task automatic wait_responses(input string what);
    int cycles;
    cycles = 0;
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      tick_wait(cycles, what);
      #1; // Let the compare process pop first.
    end
  endtask

  task automatic sweep_bank();
    for (int i = 0; i < REG_COUNT; i++) read_checked(addr_t'(i << OFFSET));
    wait_responses("bank sweep reads");
  endtask

  // ##################################################
  // Response compare and back-pressure
  // ##################################################

  // A valid and ready pair seen here transfers on the next rising edge.
  always @(negedge clk) begin
    if (rst_n && s_axi_bvalid && s_axi_bready) begin
      if (exp_b.size() == 0) begin
        report_failure("B response arrived with no write outstanding");
      end else begin
        b_e = exp_b.pop_front();
        check_equal(64'(s_axi_bid), 64'(b_e.id), "bid");
        check_equal(64'(s_axi_buser), 64'(b_e.user), "buser");
        check_equal(64'(s_axi_bresp), 64'(b_e.resp), "bresp");
      end
    end
    if (rst_n && s_axi_rvalid && s_axi_rready) begin
      if (exp_r.size() == 0) begin
        report_failure("R beat arrived with no read outstanding");
      end else begin
        r_e = exp_r.pop_front();
        check_equal(64'(s_axi_rdata), 64'(r_e.data), "rdata");
        check_equal(64'(s_axi_rid), 64'(r_e.id), "rid");
        check_equal(64'(s_axi_ruser), 64'(r_e.user), "ruser");
        check_equal(64'(s_axi_rresp), 64'(r_e.resp), "rresp");
        check_equal(64'(s_axi_rlast), 64'(r_e.last), "rlast");
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (bp_on) begin
      ready_bits   = rand_bits(2);
      s_axi_bready = ready_bits[0];
      s_axi_rready = ready_bits[1];
    end else begin
      s_axi_bready = 1'b1;
      s_axi_rready = 1'b1;
    end
  end

  // ##################################################
  // Test sequence
  // ##################################################

  initial begin : main
    b_exp_t be;
    r_exp_t re;
    data_t  rd;
    addr_t  addr;
    rst_n         = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awid    = '0;
    s_axi_awlen   = '0;
    s_axi_awsize  = FULL_SIZE;
    s_axi_awburst = BURST_INCR;
    s_axi_awuser  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wlast   = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arid    = '0;
    s_axi_arlen   = '0;
    s_axi_arsize  = FULL_SIZE;
    s_axi_arburst = BURST_INCR;
    s_axi_aruser  = '0;
    for (int i = 0; i < REG_COUNT; i++) model[i] = '0;

    repeat (2) @(posedge clk);
    #1;
    check_equal(64'(s_axi_awready), 64'(0), "awready in reset");
    check_equal(64'(s_axi_wready), 64'(0), "wready in reset");
    check_equal(64'(s_axi_arready), 64'(0), "arready in reset");
    check_equal(64'(s_axi_bvalid), 64'(0), "bvalid in reset");
    check_equal(64'(s_axi_rvalid), 64'(0), "rvalid in reset");
    rst_n = 1'b1;

    // Strobed single writes, then read back.
    for (int k = 0; k < SEQ_OPS; k++) begin
      seq_addr[k] = addr_t'(rand_bits($clog2(REG_COUNT)) << OFFSET);
      write_checked(seq_addr[k], data_t'(rand_bits(DATA_WIDTH)), strb_t'(rand_bits(STRB_WIDTH)));
    end
    wait_responses("single write responses");
    for (int k = 0; k < SEQ_OPS; k++) read_checked(seq_addr[k]);
    wait_responses("single read responses");

    // Word index beyond the bank.
    for (int k = 0; k < 4; k++) begin
      addr = addr_t'((REG_COUNT + int'(rand_bits(8))) << OFFSET);
      write_checked(addr, data_t'(rand_bits(DATA_WIDTH)), '1);
      read_checked(addr);
    end
    wait_responses("out of range responses");
    sweep_bank();

    // Bursts are drained or padded with SLVERR.
    be.id   = id_t'(rand_bits(ID_WIDTH));
    be.user = user_t'(rand_bits(USER_WIDTH));
    be.resp = RESP_SLVERR;
    exp_b.push_back(be);
    issue_write(addr_t'(rand_bits($clog2(REG_COUNT)) << OFFSET), data_t'(rand_bits(DATA_WIDTH)),
                '1, be.id, be.user, 8'd3);
    wait_responses("write burst response");
    re.id   = id_t'(rand_bits(ID_WIDTH));
    re.user = user_t'(rand_bits(USER_WIDTH));
    re.resp = RESP_SLVERR;
    re.data = '0;
    for (int i = 0; i <= 5; i++) begin
      re.last = (i == 5);
      exp_r.push_back(re);
    end
    issue_read('0, re.id, re.user, 8'd5);
    wait_responses("read burst beats");
    sweep_bank();

    // Concurrent writes to the lower half and reads from the upper half.
    for (int k = 0; k < MIX_OPS; k++) begin
      mix_waddr[k] = addr_t'(rand_bits($clog2(REG_COUNT / 2)) << OFFSET);
      mix_wdata[k] = data_t'(rand_bits(DATA_WIDTH));
      mix_wstrb[k] = strb_t'(rand_bits(STRB_WIDTH));
      mix_b[k].id   = id_t'(rand_bits(ID_WIDTH));
      mix_b[k].user = user_t'(rand_bits(USER_WIDTH));
      mix_b[k].resp = model_access(1'b1, mix_waddr[k], mix_wdata[k], mix_wstrb[k], rd);
      exp_b.push_back(mix_b[k]);
      mix_raddr[k] = addr_t'((REG_COUNT / 2 + int'(rand_bits($clog2(REG_COUNT / 2)))) << OFFSET);
      mix_r[k].id   = id_t'(rand_bits(ID_WIDTH));
      mix_r[k].user = user_t'(rand_bits(USER_WIDTH));
      mix_r[k].resp = model_access(1'b0, mix_raddr[k], '0, '0, rd);
      mix_r[k].data = rd;
      mix_r[k].last = 1'b1;
      exp_r.push_back(mix_r[k]);
    end
    @(negedge clk);
    bp_on = 1'b1;
    fork
      for (int k = 0; k < MIX_OPS; k++) begin
        issue_write(mix_waddr[k], mix_wdata[k], mix_wstrb[k], mix_b[k].id, mix_b[k].user, '0);
      end
      for (int k = 0; k < MIX_OPS; k++) begin
        issue_read(mix_raddr[k], mix_r[k].id, mix_r[k].user, '0);
      end
    join
    wait_responses("concurrent responses");
    bp_on = 1'b0;
    sweep_bank();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== logic/axi_reflect_top.sv ====
`timescale 1ns/1ps

module axi_reflect_top #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int USER_WIDTH = 2,
  parameter int REG_COUNT  = regbank_pkg::REG_COUNT_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    s_axi_awvalid,
  input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic [ID_WIDTH-1:0]     s_axi_awid,
  input  axi_pkg::axi_len_t       s_axi_awlen,
  input  logic [2:0]              s_axi_awsize,
  input  logic [1:0]              s_axi_awburst,
  input  logic [USER_WIDTH-1:0]   s_axi_awuser,
  output logic                    s_axi_awready,
  input  logic                    s_axi_wvalid,
  input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wlast,
  output logic                    s_axi_wready,
  output logic                    s_axi_bvalid,
  output logic [ID_WIDTH-1:0]     s_axi_bid,
  output axi_pkg::axi_resp_t      s_axi_bresp,
  output logic [USER_WIDTH-1:0]   s_axi_buser,
  input  logic                    s_axi_bready,

  input  logic                    s_axi_arvalid,
  input  logic [ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic [ID_WIDTH-1:0]     s_axi_arid,
  input  axi_pkg::axi_len_t       s_axi_arlen,
  input  logic [2:0]              s_axi_arsize,
  input  logic [1:0]              s_axi_arburst,
  input  logic [USER_WIDTH-1:0]   s_axi_aruser,
  output logic                    s_axi_arready,
  output logic                    s_axi_rvalid,
  output logic [DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [ID_WIDTH-1:0]     s_axi_rid,
  output axi_pkg::axi_resp_t      s_axi_rresp,
  output logic [USER_WIDTH-1:0]   s_axi_ruser,
  output logic                    s_axi_rlast,
  input  logic                    s_axi_rready
);

  axil_wr_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) wr_if ();
  axil_rd_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) rd_if ();
  bank_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) bank_bus ();

  // AXI ports match the reflector port names one to one.
  axi_reflect_wr #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH),
    .USER_WIDTH(USER_WIDTH)
  ) axi_reflect_wr_inst (
    .*,
    .lite(wr_if)
  );

  axi_reflect_rd #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH),
    .USER_WIDTH(USER_WIDTH)
  ) axi_reflect_rd_inst (
    .*,
    .lite(rd_if)
  );

  axil_bank_arbiter axil_bank_arbiter_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .wr   (wr_if),
    .rd   (rd_if),
    .bank (bank_bus)
  );

  reg_bank #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .REG_COUNT (REG_COUNT)
  ) reg_bank_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .bank (bank_bus)
  );

endmodule

// ==== logic/axi_reflect_rd.sv ====
`timescale 1ns/1ps

module axi_reflect_rd #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int USER_WIDTH = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s_axi_arvalid,
  input  logic [ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic [ID_WIDTH-1:0]   s_axi_arid,
  input  axi_pkg::axi_len_t     s_axi_arlen,
  input  logic [2:0]            s_axi_arsize,
  input  logic [1:0]            s_axi_arburst,
  input  logic [USER_WIDTH-1:0] s_axi_aruser,
  output logic                  s_axi_arready,
  output logic                  s_axi_rvalid,
  output logic [DATA_WIDTH-1:0] s_axi_rdata,
  output logic [ID_WIDTH-1:0]   s_axi_rid,
  output axi_pkg::axi_resp_t    s_axi_rresp,
  output logic [USER_WIDTH-1:0] s_axi_ruser,
  output logic                  s_axi_rlast,
  input  logic                  s_axi_rready,
  axil_rd_if.master             lite
);
  import axi_pkg::*;

  localparam logic [2:0] FULL_SIZE = 3'($clog2(DATA_WIDTH / 8));

  typedef enum logic [1:0] {IDLE, ISSUE, RESP} state_t;

  state_t                state;
  logic [ADDR_WIDTH-1:0] addr_q;
  axi_len_t              len_q;
  axi_len_t              beat_q;
  logic                  ar_pend;
  logic                  ar_fire;
  logic                  r_fire;
  logic                  lite_r_fire;
  logic                  unsupported;

  assign ar_fire     = s_axi_arvalid && s_axi_arready;
  assign r_fire      = s_axi_rvalid && s_axi_rready;
  assign lite_r_fire = lite.rvalid && lite.rready;
  assign unsupported = (s_axi_arlen != '0) || (s_axi_arburst == BURST_RESERVED) ||
                       (s_axi_arsize > FULL_SIZE);

  assign lite.araddr  = addr_q;
  assign lite.arvalid = ar_pend;
  assign lite.rready  = (state == ISSUE) && !ar_pend;
  assign s_axi_rlast  = (beat_q == len_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= IDLE;
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      ar_pend       <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          s_axi_arready <= !ar_fire;
          if (ar_fire && unsupported) begin
            s_axi_rvalid <= 1'b1; // Error beats need no bank access.
            state        <= RESP;
          end else if (ar_fire) begin
            ar_pend <= 1'b1;
            state   <= ISSUE;
          end
        end
        ISSUE: begin
          if (lite.arvalid && lite.arready) ar_pend <= 1'b0;
          if (lite_r_fire) begin
            s_axi_rvalid <= 1'b1;
            state        <= RESP;
          end
        end
        default: begin
          if (r_fire && s_axi_rlast) begin
            s_axi_rvalid <= 1'b0;
            state        <= IDLE;
          end
        end
      endcase
    end
  end

  // Payload, reflected fields and beat count.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q      <= s_axi_araddr;
      len_q       <= s_axi_arlen;
      beat_q      <= '0;
      s_axi_rid   <= s_axi_arid;
      s_axi_ruser <= s_axi_aruser;
      s_axi_rdata <= '0;
      s_axi_rresp <= RESP_SLVERR;
    end else if (r_fire) begin
      beat_q <= beat_q + 8'd1;
    end
    if (lite_r_fire) begin
      s_axi_rdata <= lite.rdata;
      s_axi_rresp <= lite.rresp;
    end
  end

endmodule

// ==== logic/axi_reflect_wr.sv ====
`timescale 1ns/1ps

module axi_reflect_wr #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int USER_WIDTH = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s_axi_awvalid,
  input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic [ID_WIDTH-1:0]     s_axi_awid,
  input  axi_pkg::axi_len_t       s_axi_awlen,
  input  logic [2:0]              s_axi_awsize,
  input  logic [1:0]              s_axi_awburst,
  input  logic [USER_WIDTH-1:0]   s_axi_awuser,
  output logic                    s_axi_awready,
  input  logic                    s_axi_wvalid,
  input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wlast,
  output logic                    s_axi_wready,
  output logic                    s_axi_bvalid,
  output logic [ID_WIDTH-1:0]     s_axi_bid,
  output axi_pkg::axi_resp_t      s_axi_bresp,
  output logic [USER_WIDTH-1:0]   s_axi_buser,
  input  logic                    s_axi_bready,
  axil_wr_if.master               lite
);
  import axi_pkg::*;

  localparam logic [2:0] FULL_SIZE = 3'($clog2(DATA_WIDTH / 8));

  typedef enum logic [1:0] {IDLE, DRAIN, ISSUE, RESP} state_t;

  state_t                  state;
  logic                    bad_q; // Answer with SLVERR, bank untouched.
  logic [ADDR_WIDTH-1:0]   addr_q;
  logic [DATA_WIDTH-1:0]   wdata_q;
  logic [DATA_WIDTH/8-1:0] wstrb_q;
  logic                    aw_pend;
  logic                    w_pend;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    lite_b_fire;
  logic                    unsupported;

  assign aw_fire     = s_axi_awvalid && s_axi_awready;
  assign w_fire      = s_axi_wvalid && s_axi_wready;
  assign lite_b_fire = lite.bvalid && lite.bready;

  // Bursts, reserved burst type and sizes wider than the bus.
  assign unsupported = (s_axi_awlen != '0) || (s_axi_awburst == BURST_RESERVED) ||
                       (s_axi_awsize > FULL_SIZE);

  assign lite.awaddr  = addr_q;
  assign lite.awvalid = aw_pend;
  assign lite.wdata   = wdata_q;
  assign lite.wstrb   = wstrb_q;
  assign lite.wvalid  = w_pend;
  assign lite.bready  = (state == ISSUE) && !aw_pend && !w_pend;

  // ##################################################
  // Control
  // ##################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= IDLE;
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      aw_pend       <= 1'b0;
      w_pend        <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          s_axi_awready <= !aw_fire;
          if (aw_fire) begin
            s_axi_wready <= 1'b1;
            state        <= DRAIN;
          end
        end
        DRAIN: begin
          if (w_fire && !bad_q) begin
            s_axi_wready <= 1'b0;
            aw_pend      <= 1'b1;
            w_pend       <= 1'b1;
            state        <= ISSUE;
          end else if (w_fire && s_axi_wlast) begin
            s_axi_wready <= 1'b0;
            s_axi_bvalid <= 1'b1;
            state        <= RESP;
          end
        end
        ISSUE: begin
          if (lite.awvalid && lite.awready) aw_pend <= 1'b0;
          if (lite.wvalid && lite.wready) w_pend <= 1'b0;
          if (lite_b_fire) begin
            s_axi_bvalid <= 1'b1;
            state        <= RESP;
          end
        end
        default: begin
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            state        <= IDLE;
          end
        end
      endcase
    end
  end

  // Request payload and the reflected ID and user.
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q      <= s_axi_awaddr;
      bad_q       <= unsupported;
      s_axi_bid   <= s_axi_awid;
      s_axi_buser <= s_axi_awuser;
      s_axi_bresp <= RESP_SLVERR;
    end
    if (w_fire) begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
    if (lite_b_fire) s_axi_bresp <= lite.bresp;
  end

endmodule

// ==== logic/axil_bank_arbiter.sv ====
`timescale 1ns/1ps

module axil_bank_arbiter (
  input logic       clk,
  input logic       rst_n,
  axil_wr_if.slave  wr,
  axil_rd_if.slave  rd,
  bank_if.master    bank
);
  import axi_pkg::*;
  import regbank_pkg::*;

  logic      wr_elig;
  logic      rd_elig;
  logic      busy;
  logic      grant_wr;
  logic      grant_rd;
  logic      last_rd; // Read side won the last contest.
  axi_resp_t resp;

  // ##################################################
  // Grant
  // ##################################################

  assign wr_elig = wr.awvalid && wr.wvalid;
  assign rd_elig = rd.arvalid;
  assign busy    = wr.bvalid || rd.rvalid; // One access in flight at a time.

  // Whoever lost last time wins a tie.
  assign grant_wr = !busy && wr_elig && (!rd_elig || last_rd);
  assign grant_rd = !busy && rd_elig && (!wr_elig || !last_rd);

  assign wr.awready = grant_wr;
  assign wr.wready  = grant_wr;
  assign rd.arready = grant_rd;

  // ##################################################
  // Bank access and response
  // ##################################################

  assign bank.req   = grant_wr || grant_rd;
  assign bank.we    = grant_wr;
  assign bank.addr  = grant_wr ? wr.awaddr : rd.araddr;
  assign bank.wdata = wr.wdata;
  assign bank.wstrb = wr.wstrb;

  // Bank outputs hold until the next req, which waits for this response.
  assign resp     = (bank.err == BANK_OUT_OF_RANGE) ? RESP_DECERR : RESP_OKAY;
  assign wr.bresp = resp;
  assign rd.rresp = resp;
  assign rd.rdata = bank.rdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_rd   <= 1'b0;
      wr.bvalid <= 1'b0;
      rd.rvalid <= 1'b0;
    end else begin
      if (grant_wr || grant_rd) begin
        last_rd <= grant_rd;
      end

      if (grant_wr) begin
        wr.bvalid <= 1'b1;
      end else if (wr.bready) begin
        wr.bvalid <= 1'b0;
      end

      if (grant_rd) begin
        rd.rvalid <= 1'b1;
      end else if (rd.rready) begin
        rd.rvalid <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32,
  parameter int REG_COUNT  = regbank_pkg::REG_COUNT_DEFAULT
) (
  input logic   clk,
  input logic   rst_n,
  bank_if.slave bank
);
  import regbank_pkg::*;

  localparam int STRB_WIDTH  = DATA_WIDTH / 8;
  localparam int OFFSET      = $clog2(STRB_WIDTH);
  localparam int IDX_WIDTH   = ADDR_WIDTH - OFFSET;
  localparam int SLOT_WIDTH  = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

  logic [DATA_WIDTH-1:0] mem [REG_COUNT];
  logic [IDX_WIDTH-1:0]  word_idx;
  logic [SLOT_WIDTH-1:0] slot;
  logic                  in_range;

  assign word_idx = bank.addr[ADDR_WIDTH-1:OFFSET]; // Drop the byte offset.
  assign slot     = word_idx[SLOT_WIDTH-1:0];
  assign in_range = (word_idx < IDX_WIDTH'(REG_COUNT));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        mem[i] <= '0;
      end
    end else if (bank.req && bank.we && in_range) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (bank.wstrb[b]) mem[slot][b*8 +: 8] <= bank.wdata[b*8 +: 8];
      end
    end
  end

  // One cycle read. Out of range reads zero.
  always_ff @(posedge clk) begin
    if (bank.req) begin
      bank.rdata <= in_range ? mem[slot] : '0;
      bank.err   <= in_range ? BANK_OK : BANK_OUT_OF_RANGE;
    end
  end

endmodule

// ==== logic/axil_if.sv ====
`timescale 1ns/1ps

interface axil_wr_if #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32
);
  import axi_pkg::*;

  logic [ADDR_WIDTH-1:0]   awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [DATA_WIDTH/8-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  axi_resp_t               bresp;
  logic                    bvalid;
  logic                    bready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );
endinterface

interface axil_rd_if #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32
);
  import axi_pkg::*;

  logic [ADDR_WIDTH-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_WIDTH-1:0] rdata;
  axi_resp_t             rresp;
  logic                  rvalid;
  logic                  rready;

  modport master (output araddr, arvalid, rready, input arready, rdata, rresp, rvalid);
  modport slave (input araddr, arvalid, rready, output arready, rdata, rresp, rvalid);
endinterface

// Single port into the register bank. Read data follows req by one cycle.
interface bank_if #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32
);
  import regbank_pkg::*;

  logic                    req;
  logic                    we;
  logic [ADDR_WIDTH-1:0]   addr;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [DATA_WIDTH/8-1:0] wstrb;
  logic [DATA_WIDTH-1:0]   rdata;
  bank_err_e               err;

  modport master (output req, we, addr, wdata, wstrb, input rdata, err);
  modport slave (input req, we, addr, wdata, wstrb, output rdata, err);
endinterface

// ==== logic/regbank_pkg.sv ====
package regbank_pkg;

  // Words in the bank unless the top level says otherwise.
  localparam int REG_COUNT_DEFAULT = 16;

  // Outcome of the word index check.
  typedef enum logic {
    BANK_OK,
    BANK_OUT_OF_RANGE
  } bank_err_e;

endpackage

// ==== logic/axi_pkg.sv ====
package axi_pkg;

  // ##################################################
  // Response codes
  // ##################################################

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10; // Unsupported burst or encoding.
  localparam axi_resp_t RESP_DECERR = 2'b11; // Address outside the bank.

  // ##################################################
  // Burst length
  // ##################################################

  // Beats minus one, as carried on awlen and arlen.
  typedef logic [7:0] axi_len_t;

  // Reserved burst encoding.
  localparam logic [1:0] BURST_RESERVED = 2'b11;

endpackage
